/* smc_mac_lite.f */
common/smc_mac_pkg.sv
hw/smc_mac/smc_access_ctrl.sv
hw/smc_mac/smc_lane_steer.sv
hw/smc_mac/smc_mac_lite.sv
verif/smc_mac_assertions.sv
verif/tb_smc_mac_lite.sv

/* Makefile */
# Verilator build, run and lint for the multiple-access controller

VERILATOR ?= verilator
TB_TOP    ?= tb_smc_mac_lite
RTL_TOP   ?= smc_mac_lite
FILELIST  ?= smc_mac_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_smc_mac_lite.sv */
//----------------------------------------------------------------------
// testbench for the multiple-access controller: byte, halfword and
// word reads and writes over the 8-bit bus, watchdog, result line
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_smc_mac_lite;

  import smc_mac_pkg::*;

  localparam int clk_half        = 4;                   // 8 ns period
  localparam int num_tests       = 6;
  localparam int watchdog_cycles = num_tests * 12 + 20;

  logic        sys_clk26;
  logic        n_sys_reset26;
  logic        valid_access;
  xfer_size_t  xfer_size;
  logic        smc_done;
  smc_state_t  smc_nextstate;
  logic        latch_data;
  word_t       data_smc;
  word_t       write_data;
  access_cnt_t r_num_access;
  logic        mac_done;
  xfer_size_t  v_xfer_size;
  word_t       read_data;
  word_t       smc_data;
  int          err_cnt = 0;

  smc_mac_lite i_smc_mac_lite (.*);

  // counter, done and write lane rules
  bind smc_mac_lite smc_mac_assertions i_mac_assertions (.*);

  always #clk_half sys_clk26 = ~sys_clk26;

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      err_cnt++;
      $display("** Error [%s] expected %08h actual %08h", name, exp, act);
    end
  endtask

  //--------------------------------------------------------------------
  // one transfer, accesses run until mac_done flags the last one
  //--------------------------------------------------------------------
  task automatic run_xfer(input string name, input xfer_size_t size, input logic is_read);
    byte_t sent[$];
    word_t rnd;
    word_t exp;
    logic  last;
    int    want;
    want = (size == xsiz_32) ? 4 : ((size == xsiz_16) ? 2 : 1);
    last = 1'b0;
    @(posedge sys_clk26);
    #1;
    valid_access  = 1'b1;            // address cycle
    xfer_size     = size;
    smc_nextstate = smc_le;
    if (!is_read)
      write_data = $urandom();       // held for the whole transfer
    @(negedge sys_clk26);
    check_word(name, {30'd0, size}, {30'd0, v_xfer_size});   // live size
    @(posedge sys_clk26);
    #1;
    valid_access = 1'b0;
    xfer_size    = xsiz_8;
    while (!last)
    begin
      smc_nextstate = smc_rw;        // one wait state per access
      latch_data    = 1'b0;
      smc_done      = 1'b0;
      @(posedge sys_clk26);
      #1;
      rnd  = $urandom();
      last = mac_done;
      sent.push_back(rnd[7:0]);
      data_smc   = rnd;              // upper lanes are junk
      latch_data = is_read;
      smc_done   = 1'b1;
      if (!last)
        smc_nextstate = smc_rw;
      else
        smc_nextstate = is_read ? smc_idle : smc_store;   // last done, counter holds
      @(negedge sys_clk26);          // combinational output settled
      check_word(name, {30'd0, size}, {30'd0, v_xfer_size});   // held size
      if (last && is_read)
      begin
        case (size)
          xsiz_32: exp = {sent[0], sent[1], sent[2], sent[3]};  // first byte on top
          xsiz_16: exp = {sent[0], sent[1], sent[0], sent[1]};
          default: exp = {4{sent[0]}};
        endcase
        check_word(name, exp, read_data);
      end
      @(posedge sys_clk26);
      #1;
      latch_data    = 1'b0;
      smc_done      = 1'b0;
      smc_nextstate = smc_idle;
    end
    if (sent.size() != want)
    begin
      err_cnt++;
      $display("** Error [%s] accesses expected %0d actual %0d", name, want, sent.size());
    end
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial
  begin
    int asrt_cnt;
    void'($urandom(53524));
    sys_clk26     = 1'b0;
    n_sys_reset26 = 1'b0;
    valid_access  = 1'b0;
    xfer_size     = xsiz_8;
    smc_done      = 1'b0;
    smc_nextstate = smc_idle;
    latch_data    = 1'b0;
    data_smc      = '0;
    write_data    = '0;
    repeat (4) @(posedge sys_clk26);
    #1;
    n_sys_reset26 = 1'b1;
    check_word("reset_count", 32'd0, {30'd0, r_num_access});
    check_word("reset_done", 32'd1, {31'd0, mac_done});
    check_word("reset_read", 32'd0, read_data);      // empty collector
    run_xfer("read_word_a", xsiz_32, 1'b1);
    run_xfer("read_word_b", xsiz_32, 1'b1);
    run_xfer("read_half", xsiz_16, 1'b1);
    run_xfer("read_byte", xsiz_8, 1'b1);
    run_xfer("write_word", xsiz_32, 1'b0);
    run_xfer("write_half", xsiz_16, 1'b0);
    @(posedge sys_clk26);
    #1;
    asrt_cnt = i_smc_mac_lite.i_mac_assertions.fail_cnt;
    $display("check errors: %0d, assertion failures: %0d", err_cnt, asrt_cnt);
    if (err_cnt == 0 && asrt_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // watchdog, budget of 12 cycles per test plus reset margin
  initial
  begin
    #(watchdog_cycles * 2 * clk_half);
    $display("watchdog expired after %0d clock periods, run did not finish", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/smc_mac_assertions.sv */
//----------------------------------------------------------------------
// concurrent checks on start count, access counter, done flag and
// write byte lane, bound into the controller top
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module smc_mac_assertions (
  input  wire                      sys_clk26,
  input  wire                      n_sys_reset26,
  input  wire                      valid_access,
  input  smc_mac_pkg::xfer_size_t  xfer_size,
  input  wire                      smc_done,
  input  smc_mac_pkg::smc_state_t  smc_nextstate,
  input  smc_mac_pkg::access_cnt_t r_num_access,
  input  wire                      mac_done,
  input  smc_mac_pkg::word_t       write_data,
  input  smc_mac_pkg::word_t       smc_data
);

  import smc_mac_pkg::*;

  int         fail_cnt = 0;   // read back by the testbench
  logic       count_step;     // completion that moves the counter
  logic [4:0] lane_base;      // bit offset of the current lane

  assign count_step = smc_done && (smc_nextstate != smc_idle) && (smc_nextstate != smc_store);
  assign lane_base  = {r_num_access, 3'b000};

  // accesses left after the first one, per size
  function automatic access_cnt_t start_count(input xfer_size_t size);
    if (size == xsiz_32)
      return acc_last_word;
    else if (size == xsiz_16)
      return acc_last_half;
    else
      return acc_last_byte;
  endfunction

  //--------------------------------------------------------------------
  // counter rules
  //--------------------------------------------------------------------
  start_load: assert property (@(posedge sys_clk26) disable iff (!n_sys_reset26)
    valid_access |=> (r_num_access == start_count($past(xfer_size))))
    else begin fail_cnt++; $error("start count wrong after valid_access"); end

  count_dec: assert property (@(posedge sys_clk26) disable iff (!n_sys_reset26)
    (count_step && !valid_access) |=> (r_num_access == $past(r_num_access) - 2'd1))
    else begin fail_cnt++; $error("counter did not step on smc_done"); end

  // idle or store next state, or no done at all
  count_hold: assert property (@(posedge sys_clk26) disable iff (!n_sys_reset26)
    (!count_step && !valid_access) |=> (r_num_access == $past(r_num_access)))
    else begin fail_cnt++; $error("counter moved without a counted smc_done"); end

  done_flag: assert property (@(posedge sys_clk26) disable iff (!n_sys_reset26)
    mac_done == (r_num_access == 2'd0))
    else begin fail_cnt++; $error("mac_done does not match a zero count"); end

  //--------------------------------------------------------------------
  // write lane, low byte only
  //--------------------------------------------------------------------
  write_lane: assert property (@(posedge sys_clk26) disable iff (!n_sys_reset26)
    smc_data == {24'h0, write_data[lane_base +: 8]})
    else begin fail_cnt++; $error("smc_data carries the wrong write byte"); end

endmodule

`default_nettype wire

/* hw/smc_mac/smc_mac_lite.sv */
//----------------------------------------------------------------------
// multiple-access controller top, access control plus lane datapath
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module smc_mac_lite (
  input  wire                      sys_clk26,
  input  wire                      n_sys_reset26,
  input  wire                      valid_access,    // new transfer
  input  smc_mac_pkg::xfer_size_t  xfer_size,
  input  wire                      smc_done,        // access finished
  input  smc_mac_pkg::smc_state_t  smc_nextstate,
  input  wire                      latch_data,      // read byte valid
  input  smc_mac_pkg::word_t       data_smc,
  input  smc_mac_pkg::word_t       write_data,
  output smc_mac_pkg::access_cnt_t r_num_access,
  output logic                     mac_done,        // last access
  output smc_mac_pkg::xfer_size_t  v_xfer_size,
  output smc_mac_pkg::word_t       read_data,       // to internal bus
  output smc_mac_pkg::word_t       smc_data         // to external bus
);

  import smc_mac_pkg::*;

  xfer_size_t r_xfer_size;   // held size, steers the read mux

  // ------------------------------------------------------------------
  // size register and access counter
  // ------------------------------------------------------------------
  smc_access_ctrl i_access_ctrl (
    .sys_clk26     (sys_clk26),
    .n_sys_reset26 (n_sys_reset26),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .r_xfer_size   (r_xfer_size),
    .v_xfer_size   (v_xfer_size),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done)
  );

  // ------------------------------------------------------------------
  // byte lanes, read gather and write select
  // ------------------------------------------------------------------
  smc_lane_steer i_lane_steer (
    .sys_clk26     (sys_clk26),
    .n_sys_reset26 (n_sys_reset26),
    .latch_data    (latch_data),
    .r_xfer_size   (r_xfer_size),
    .r_num_access  (r_num_access),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

endmodule

`default_nettype wire

/* hw/smc_mac/smc_lane_steer.sv */
//----------------------------------------------------------------------
// byte-lane datapath: read byte collector, read-data lane mux
// and write byte select for the 8-bit external bus
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module smc_lane_steer (
  input  wire                      sys_clk26,
  input  wire                      n_sys_reset26,   // async, active low
  input  wire                      latch_data,      // read byte valid
  input  smc_mac_pkg::xfer_size_t  r_xfer_size,     // held transfer size
  input  smc_mac_pkg::access_cnt_t r_num_access,    // current byte lane
  input  smc_mac_pkg::word_t       data_smc,        // external read data
  input  smc_mac_pkg::word_t       write_data,      // held internal write word
  output smc_mac_pkg::word_t       read_data,       // word to internal bus
  output smc_mac_pkg::word_t       smc_data         // data to external bus
);

  import smc_mac_pkg::*;

  word_t r_collect;    // bytes gathered so far
  byte_t rd_byte;      // only the low byte of the bus carries data
  byte_t lo_byte;      // live or stored lane 0
  byte_t wr_byte;      // lane picked from write_data

  assign rd_byte = data_smc[7:0];

  //--------------------------------------------------------------------
  // read collector
  //--------------------------------------------------------------------
  // first beat of a word lands in lane 3, lanes below start clean
  always_ff @(posedge sys_clk26 or negedge n_sys_reset26)
  begin
    if (!n_sys_reset26)
    begin
      r_collect <= '0;
    end
    else if (latch_data)
    begin
      case (r_num_access)
        2'd3:
        begin
          r_collect[31:24] <= rd_byte;
          r_collect[23:0]  <= '0;
        end
        2'd2:
        begin
          r_collect[23:16] <= rd_byte;   // lane 3 kept
          r_collect[15:0]  <= '0;
        end
        2'd1:
        begin
          r_collect[15:8] <= rd_byte;    // upper lanes kept
          r_collect[7:0]  <= '0;
        end
        default:
        begin
          r_collect[7:0] <= rd_byte;     // final beat
        end
      endcase
    end
  end

  //--------------------------------------------------------------------
  // read data to internal bus
  //--------------------------------------------------------------------
  // last beat bypasses the collector so the word is ready at once
  assign lo_byte = latch_data ? rd_byte : r_collect[7:0];

  always_comb
  begin
    case (r_xfer_size)
      xsiz_32:
      begin
        read_data = {r_collect[31:8], lo_byte};
      end
      xsiz_16:
      begin
        // halfword mirrored into both halves
        read_data = {r_collect[15:8], lo_byte, r_collect[15:8], lo_byte};
      end
      default:
      begin
        read_data = {4{lo_byte}};          // byte on every lane
      end
    endcase
  end

  //--------------------------------------------------------------------
  // write data to external bus
  //--------------------------------------------------------------------
  // count 3 sends the top byte first, count 0 the bottom one
  always_comb
  begin
    case (r_num_access)
      2'd3:
        wr_byte = write_data[31:24];
      2'd2:
        wr_byte = write_data[23:16];
      2'd1:
        wr_byte = write_data[15:8];
      default:
        wr_byte = write_data[7:0];
    endcase
  end

  assign smc_data = {24'h0, wr_byte};   // upper lanes unused on 8-bit bus

endmodule

`default_nettype wire

/* hw/smc_mac/smc_access_ctrl.sv */
//----------------------------------------------------------------------
// transfer-size register, start-count decode, access down counter
// and last-access flag
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module smc_access_ctrl (
  input  wire                      sys_clk26,
  input  wire                      n_sys_reset26,   // async, active low
  input  wire                      valid_access,    // address cycle strobe
  input  smc_mac_pkg::xfer_size_t  xfer_size,       // valid with valid_access
  input  wire                      smc_done,        // end of one access
  input  smc_mac_pkg::smc_state_t  smc_nextstate,   // controller next state
  output smc_mac_pkg::xfer_size_t  r_xfer_size,     // held size
  output smc_mac_pkg::xfer_size_t  v_xfer_size,     // live or held size
  output smc_mac_pkg::access_cnt_t r_num_access,    // accesses still to go
  output logic                     mac_done         // last access running
);

  import smc_mac_pkg::*;

  access_cnt_t start_cnt;   // decoded count for the new transfer
  logic        acc_step;    // one access completed, more to follow

  //--------------------------------------------------------------------
  // transfer size
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk26 or negedge n_sys_reset26)
  begin
    if (!n_sys_reset26)
      r_xfer_size <= xsiz_8;
    else if (valid_access)
      r_xfer_size <= xfer_size;      // hold for the whole transfer
  end

  // size seen by the rest of the controller in the address cycle
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  //--------------------------------------------------------------------
  // number of byte accesses needed
  //--------------------------------------------------------------------
  always_comb
  begin
    case (xfer_size)
      xsiz_16:
        start_cnt = acc_last_half;   // two beats
      xsiz_32:
        start_cnt = acc_last_word;   // four beats
      xsiz_8, xsiz_rsvd:
        start_cnt = acc_last_byte;   // single beat
      default:
        start_cnt = acc_last_byte;
    endcase
  end

  //--------------------------------------------------------------------
  // access counter
  //--------------------------------------------------------------------
  // a done leading into idle or store closes the transfer, no count
  assign acc_step = smc_done &&
                    (smc_nextstate != smc_idle) &&
                    (smc_nextstate != smc_store);

  always_ff @(posedge sys_clk26 or negedge n_sys_reset26)
  begin
    if (!n_sys_reset26)
      r_num_access <= '0;
    else if (valid_access)
      r_num_access <= start_cnt;              // new transfer
    else if (acc_step)
      r_num_access <= r_num_access - 2'd1;    // next byte lane
  end

  // last access when nothing is left
  assign mac_done = (r_num_access == 2'd0);

endmodule

`default_nettype wire

/* common/smc_mac_pkg.sv */
//----------------------------------------------------------------------
// size codes, external state codes, width types and start counts
// shared by the multiple-access controller
//----------------------------------------------------------------------
`default_nettype none

package smc_mac_pkg;

  // ------------------------------------------------------------------
  // data widths
  // ------------------------------------------------------------------
  typedef logic [31:0] word_t;        // internal bus word
  typedef logic [7:0]  byte_t;        // one external bus beat

  // remaining accesses after the current one
  typedef logic [1:0]  access_cnt_t;

  // internal transfer size, sampled with valid_access
  typedef logic [1:0]  xfer_size_t;

  localparam xfer_size_t xsiz_8    = 2'h0;  // byte
  localparam xfer_size_t xsiz_16   = 2'h1;  // halfword
  localparam xfer_size_t xsiz_32   = 2'h2;  // word
  localparam xfer_size_t xsiz_rsvd = 2'h3;  // reserved, treated as byte

  // ------------------------------------------------------------------
  // external controller state, one-hot
  // only idle and store matter to the access counter
  // ------------------------------------------------------------------
  typedef enum logic [4:0] {
    smc_idle  = 5'b00001,
    smc_le    = 5'b00010,   // latch enable / address phase
    smc_rw    = 5'b00100,   // read or write strobe
    smc_store = 5'b01000,   // store phase
    smc_float = 5'b10000    // bus turnaround
  } smc_state_t;

  // start count per transfer size, 8-bit external bus
  localparam access_cnt_t acc_last_byte = 2'd0;  // one access
  localparam access_cnt_t acc_last_half = 2'd1;  // two accesses
  localparam access_cnt_t acc_last_word = 2'd3;  // four accesses

endpackage

`default_nettype wire
